//--- Makefile
SIM      ?= verilator
FLAGS    ?= --binary --timing --assert
TOP      ?= tbFlowMux
FILELIST ?= verilog.f

OBJDIR := obj_dir
BIN    := $(OBJDIR)/V$(TOP)
SRCS   := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# Pass only when the pass line shows up in the output
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf $(OBJDIR)

//--- design/flowCfgPkg.sv
// Structural defaults for the flow mux subsystem.
// The top level takes its parameter defaults from here, and the
// testbench uses the same values to size its DUT and checkers.

package flowCfgPkg;

  // --------------------------------------------------
  // Subsystem shape
  // --------------------------------------------------

  // Producer flows merged onto the single consumer stream
  localparam int DefaultNumFlows = 4;

  // Entries in each per-flow input queue
  localparam int DefaultFifoDepth = 4;

  // Upper bound on flows, sets the width of the flow index
  localparam int MaxNumFlows = 4;

endpackage : flowCfgPkg

//--- design/flowFifo.sv
// Per-flow input queue with ready-valid on both sides.
// A circular buffer with read and write pointers and an occupancy count.
// A pushed word reaches the head one edge later, there is no bypass path.
// pushReady stays high while the queue has a free entry.

`timescale 1ns/1ps

module flowFifo import flowTypesPkg::*; #(
  parameter type PayloadT = dataWordT,
  parameter int  Depth    = 4
) (
  input  logic    clk,
  input  logic    arstN,
  input  logic    pushValid,
  output logic    pushReady,
  input  PayloadT pushData,
  output logic    popValid,
  input  logic    popReady,
  output PayloadT popData
);

  localparam int PtrW   = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int CountW = $clog2(Depth + 1);

  // --------------------------------------------------
  // Storage and pointers
  // --------------------------------------------------
  PayloadT             mem [Depth];
  logic [PtrW-1:0]     wrPtr;
  logic [PtrW-1:0]     rdPtr;
  logic [CountW-1:0]   count;
  logic                push;
  logic                pop;

  // Full when every entry holds a word
  assign pushReady = (count != CountW'(Depth));
  assign popValid  = (count != '0);
  assign popData   = mem[rdPtr];

  assign push = pushValid && pushReady;
  assign pop  = popValid && popReady;

  // Payload store, written only on an accepted push
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wrPtr] <= pushData;
    end
  end

  // Pointer and occupancy control
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (push) begin
        // Wrap by compare so any Depth works
        wrPtr <= (wrPtr == PtrW'(Depth - 1)) ? '0 : wrPtr + PtrW'(1);
      end
      if (pop) begin
        rdPtr <= (rdPtr == PtrW'(Depth - 1)) ? '0 : rdPtr + PtrW'(1);
      end
      case ({push, pop})
        2'b10:   count <= count + CountW'(1);
        2'b01:   count <= count - CountW'(1);
        default: count <= count;
      endcase
    end
  end

  // --------------------------------------------------
  // Checks
  // --------------------------------------------------

  // Producer must hold its word while the queue is full
  pushDataStableA: assert property (@(posedge clk) disable iff (!arstN)
    pushValid && !pushReady |=> pushValid && $stable(pushData));

  // Occupancy never runs past the number of entries
  countInRangeA: assert property (@(posedge clk) disable iff (!arstN)
    count <= CountW'(Depth));

endmodule : flowFifo

//--- design/flowMuxSelect.sv
// Ready-valid mux steered by an explicit binary select.
// Purely combinational. The selected flow's valid and data pass through,
// and popReady is returned to that flow only.
// popValid and popData may change under stall when select moves, so the
// pop side does not follow the usual stability rule.
// clk and arstN are used by the checks alone.

`timescale 1ns/1ps

module flowMuxSelect import flowTypesPkg::*; #(
  parameter int NumFlows = 4
) (
  input  logic                          clk,
  input  logic                          arstN,
  input  flowIdT                        select,
  input  logic     [NumFlows-1:0]       pushValid,
  output logic     [NumFlows-1:0]       pushReady,
  input  dataWordT [NumFlows-1:0]       pushData,
  input  logic                          popReady,
  output logic                          popValid,
  output dataWordT                      popData
);

  // --------------------------------------------------
  // Forward path
  // --------------------------------------------------
  assign popValid = pushValid[select];
  assign popData  = pushData[select];

  // --------------------------------------------------
  // Return path
  // --------------------------------------------------

  // One-hot ready, only the selected flow sees it
  always_comb begin
    for (int i = 0; i < NumFlows; i++) begin
      pushReady[i] = popReady && (select == flowIdT'(i));
    end
  end

  // --------------------------------------------------
  // Checks
  // --------------------------------------------------

  // Select must name an existing flow
  selectInRangeA: assert property (@(posedge clk) disable iff (!arstN)
    select <= flowIdT'(NumFlows - 1));

  // Queues hold valid under stall, so a drop of popValid while
  // stalled can only come from the scheduler moving select
  validFallNeedsSelectA: assert property (@(posedge clk) disable iff (!arstN)
    popValid && !popReady ##1 !popValid |-> $changed(select));

endmodule : flowMuxSelect

//--- design/flowMuxTop.sv
// Top level of the flow mux subsystem.
// Per-flow queues feed a select mux steered by a round-robin scheduler,
// and a skid buffer registers each word with its flow index.
// Input to outValid takes at least two edges, more when the select
// pointer is elsewhere. Per-flow order is kept end to end.

`timescale 1ns/1ps

module flowMuxTop import flowCfgPkg::*; import flowTypesPkg::*; #(
  parameter int NumFlows  = DefaultNumFlows,
  parameter int FifoDepth = DefaultFifoDepth
) (
  input  logic                    clk,
  input  logic                    arstN,
  input  logic     [NumFlows-1:0] inValid,
  output logic     [NumFlows-1:0] inReady,
  input  dataWordT [NumFlows-1:0] inData,
  output logic                    outValid,
  input  logic                    outReady,
  output dataWordT                outData,
  output flowIdT                  outFlowId
);

  // --------------------------------------------------
  // Internal links
  // --------------------------------------------------
  logic     [NumFlows-1:0] qValid;
  logic     [NumFlows-1:0] qReady;
  dataWordT [NumFlows-1:0] qData;
  flowIdT                  select;
  logic                    muxValid;
  logic                    muxReady;
  dataWordT                muxData;
  taggedWordT              skidIn;
  taggedWordT              skidOut;

  // Input side, one queue per producer
  for (genvar i = 0; i < NumFlows; i++) begin : genQueue
    flowFifo #(
      .PayloadT(dataWordT),
      .Depth   (FifoDepth)
    ) queue0 (
      .clk      (clk),
      .arstN    (arstN),
      .pushValid(inValid[i]),
      .pushReady(inReady[i]),
      .pushData (inData[i]),
      .popValid (qValid[i]),
      .popReady (qReady[i]),
      .popData  (qData[i])
    );
  end

  // Scheduler sees a transfer only when the mux handshake completes
  flowSelectScheduler #(.NumFlows(NumFlows)) sched0 (
    .clk      (clk),
    .arstN    (arstN),
    .flowValid(qValid),
    .xferDone (muxValid && muxReady),
    .select   (select)
  );

  flowMuxSelect #(.NumFlows(NumFlows)) mux0 (
    .clk      (clk),
    .arstN    (arstN),
    .select   (select),
    .pushValid(qValid),
    .pushReady(qReady),
    .pushData (qData),
    .popReady (muxReady),
    .popValid (muxValid),
    .popData  (muxData)
  );

  // Tag each word with the flow that select names this cycle
  assign skidIn = '{flowId: select, data: muxData};

  // Output side
  flowSkidBuffer #(.PayloadT(taggedWordT)) skid0 (
    .clk     (clk),
    .arstN   (arstN),
    .inValid (muxValid),
    .inReady (muxReady),
    .inData  (skidIn),
    .outValid(outValid),
    .outReady(outReady),
    .outData (skidOut)
  );

  assign outFlowId = skidOut.flowId;
  assign outData   = skidOut.data;

endmodule : flowMuxTop

//--- design/flowSelectScheduler.sv
// Round-robin owner of the mux select.
// The pointer moves on by one flow after a transfer through the mux,
// and also after any cycle where the flow it points at had nothing to send.
// While the selected flow is valid but stalled, the pointer holds.

`timescale 1ns/1ps

module flowSelectScheduler import flowTypesPkg::*; #(
  parameter int NumFlows = 4
) (
  input  logic                clk,
  input  logic                arstN,
  input  logic [NumFlows-1:0] flowValid,
  input  logic                xferDone,
  output flowIdT              select
);

  // --------------------------------------------------
  // Advance rule
  // --------------------------------------------------
  logic   advance;
  flowIdT nextSelect;

  // Move on after a word went through or the flow was idle
  assign advance = xferDone || !flowValid[select];

  // Wrap at NumFlows, which need not be a power of two
  always_comb begin
    if (select == flowIdT'(NumFlows - 1)) begin
      nextSelect = '0;
    end else begin
      nextSelect = select + flowIdT'(1);
    end
  end

  // --------------------------------------------------
  // Pointer register
  // --------------------------------------------------
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      select <= '0;
    end else if (advance) begin
      select <= nextSelect;
    end
  end

  // --------------------------------------------------
  // Checks
  // --------------------------------------------------

  // Pointer only ever names an existing flow
  selectInRangeA: assert property (@(posedge clk) disable iff (!arstN)
    select < flowIdT'(NumFlows - 1) || select == flowIdT'(NumFlows - 1));

endmodule : flowSelectScheduler

//--- design/flowSkidBuffer.sv
// Two-entry output register for the merged stream.
// A main register drives the consumer, and a skid register catches the
// word that was in flight when back-pressure arrived.
// inReady is a register output, so outReady never reaches the mux
// combinationally. Full throughput while outReady stays high.

`timescale 1ns/1ps

module flowSkidBuffer import flowTypesPkg::*; #(
  parameter type PayloadT = taggedWordT
) (
  input  logic    clk,
  input  logic    arstN,
  input  logic    inValid,
  output logic    inReady,
  input  PayloadT inData,
  output logic    outValid,
  input  logic    outReady,
  output PayloadT outData
);

  // --------------------------------------------------
  // State
  // --------------------------------------------------
  logic    mainValid;
  logic    skidValid;
  PayloadT mainData;
  PayloadT skidData;
  logic    push;
  logic    pop;
  logic    loadMainFromIn;
  logic    loadSkid;
  logic    loadMainFromSkid;

  // Room as long as the skid entry is free
  assign inReady  = !skidValid;
  assign outValid = mainValid;
  assign outData  = mainData;

  assign push = inValid && inReady;
  assign pop  = mainValid && outReady;

  // Where an arriving or parked word goes this cycle
  assign loadMainFromSkid = skidValid && pop;
  assign loadMainFromIn   = push && (!mainValid || pop);
  assign loadSkid         = push && mainValid && !pop;

  // --------------------------------------------------
  // Control
  // --------------------------------------------------
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      mainValid <= 1'b0;
      skidValid <= 1'b0;
    end else begin
      if (loadMainFromSkid || loadMainFromIn) begin
        mainValid <= 1'b1;
      end else if (pop) begin
        mainValid <= 1'b0;
      end
      // Skid fills on a stalled push and drains into main on a pop
      if (loadSkid) begin
        skidValid <= 1'b1;
      end else if (loadMainFromSkid) begin
        skidValid <= 1'b0;
      end
    end
  end

  // --------------------------------------------------
  // Payload
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (loadMainFromSkid) begin
      mainData <= skidData;
    end else if (loadMainFromIn) begin
      mainData <= inData;
    end
    if (loadSkid) begin
      skidData <= inData;
    end
  end

  // Consumer sees a steady word until it takes it
  outHoldA: assert property (@(posedge clk) disable iff (!arstN)
    outValid && !outReady |=> outValid && $stable(outData));

endmodule : flowSkidBuffer

//--- design/flowTypesPkg.sv
// Data types carried through the flow mux subsystem.
// Producers send dataWordT, and the output stage carries taggedWordT,
// which pairs each word with the index of the flow it came from.

package flowTypesPkg;

  import flowCfgPkg::*;

  // --------------------------------------------------
  // Payload and index types
  // --------------------------------------------------

  // One producer payload word
  typedef logic [15:0] dataWordT;

  // Flow index sized for the largest supported flow count
  typedef logic [$clog2(MaxNumFlows)-1:0] flowIdT;

  // Word as seen by the consumer
  // Flow index sits in the upper bits
  typedef struct packed {
    flowIdT   flowId;
    dataWordT data;
  } taggedWordT;

endpackage : flowTypesPkg

//--- testbench/tbFlowMux.sv
// Directed testbench for the flow mux subsystem.
// Every cycle is stepped through one task that drives the producers and the
// consumer ready, and scoreboards each output against per-flow expected queues.
// Tests cover reset state, one flow, round robin, back-pressure and random traffic.

`timescale 1ns/1ps

module tbFlowMux import flowCfgPkg::*; import flowTypesPkg::*; ();

  localparam int NumFlows      = DefaultNumFlows;
  localparam int FifoDepth     = DefaultFifoDepth;
  localparam int ResetCycles   = 16;
  localparam int SingleWords   = 8;
  localparam int PressureWords = FifoDepth + 4;
  localparam int RandomWords   = 24;
  localparam int TotalWords    = SingleWords + NumFlows * FifoDepth + PressureWords
                                 + NumFlows * RandomWords;
  // Generous cycle budget per word, random stalls included
  localparam int DrainLimit    = 8 * TotalWords;
  localparam int WatchdogNs    = 4 * (ResetCycles + DrainLimit) * 10;

  logic                    clk;
  logic                    arstN;
  logic     [NumFlows-1:0] inValid;
  logic     [NumFlows-1:0] inReady;
  dataWordT [NumFlows-1:0] inData;
  logic                    outValid;
  logic                    outReady;
  dataWordT                outData;
  flowIdT                  outFlowId;

  // --------------------------------------------------
  // Scoreboard state
  // --------------------------------------------------
  dataWordT      pendQ [NumFlows][$];
  dataWordT      expQ  [NumFlows][$];
  logic [31:0]   lcgState = 32'd21850;
  logic [NumFlows-1:0] stallSeen;
  logic          rrCheck;
  logic          rrHavePrev;
  int            rrPrev;
  int            mismatchCount;
  int            otherCount;
  int            acceptedCount;
  int            outCount;

  flowMuxTop #(
    .NumFlows (NumFlows),
    .FifoDepth(FifoDepth)
  ) dut0 (
    .clk      (clk),
    .arstN    (arstN),
    .inValid  (inValid),
    .inReady  (inReady),
    .inData   (inData),
    .outValid (outValid),
    .outReady (outReady),
    .outData  (outData),
    .outFlowId(outFlowId)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Hard stop sized from the total word count of all tests
  initial begin
    #(WatchdogNs);
    $display("Timeout: watchdog expired after %0d ns, run did not finish", WatchdogNs);
    $display("TB FAILED");
    $finish;
  end

  // LCG stepping, upper bits carry the better randomness
  function automatic logic [31:0] nextRandom();
    lcgState = lcgState * 32'd1103515245 + 32'd12345;
    return lcgState;
  endfunction

  function automatic dataWordT randomWord();
    logic [31:0] r;
    r = nextRandom();
    return r[23:8];
  endfunction

  function automatic logic pendingEmpty();
    logic empty;
    empty = 1'b1;
    for (int f = 0; f < NumFlows; f++) begin
      if (pendQ[f].size() != 0) empty = 1'b0;
    end
    return empty;
  endfunction

  // Nothing left to send and nothing outstanding at the output
  function automatic logic allDelivered();
    logic done;
    done = pendingEmpty();
    for (int f = 0; f < NumFlows; f++) begin
      if (expQ[f].size() != 0) done = 1'b0;
    end
    return done;
  endfunction

  // --------------------------------------------------
  // One clock cycle: sample handshakes, then drive
  // --------------------------------------------------
  task automatic driveCycle(input logic validRandom, input logic readyRandom,
                            input logic readyLevel);
    logic [31:0] r;
    int          id;
    @(posedge clk);
    // Input side, values seen here are the pre-edge ones
    for (int f = 0; f < NumFlows; f++) begin
      if (inValid[f] && inReady[f]) begin
        expQ[f].push_back(inData[f]);
        void'(pendQ[f].pop_front());
        acceptedCount++;
      end
      if (inValid[f] && !inReady[f]) begin
        stallSeen[f] = 1'b1;
      end
    end
    // Output side, pop the queue the tag names
    if (outValid && outReady) begin
      id = int'(outFlowId);
      outCount++;
      if (expQ[id].size() == 0) begin
        $display("Unexpected word %h tagged flow %0d at %0t, nothing outstanding",
                 outData, id, $time);
        otherCount++;
      end else begin
        if (outData != expQ[id][0]) begin
          $display("Mismatch at %0t: flow %0d expected %h got %h",
                   $time, id, expQ[id][0], outData);
          mismatchCount++;
        end
        void'(expQ[id].pop_front());
      end
      if (rrCheck && rrHavePrev && outFlowId != flowIdT'((rrPrev + 1) % NumFlows)) begin
        $display("Mismatch at %0t: round robin expected flow %0d after %0d got %0d",
                 $time, (rrPrev + 1) % NumFlows, rrPrev, id);
        mismatchCount++;
      end
      rrPrev     = id;
      rrHavePrev = 1'b1;
    end
    // Producers hold valid and data while stalled
    for (int f = 0; f < NumFlows; f++) begin
      if (!(inValid[f] && !inReady[f])) begin
        r = nextRandom();
        if (pendQ[f].size() != 0 && (!validRandom || r[16])) begin
          inValid[f] <= 1'b1;
          inData[f]  <= pendQ[f][0];
        end else begin
          inValid[f] <= 1'b0;
        end
      end
    end
    r = nextRandom();
    outReady <= readyRandom ? r[20] : readyLevel;
  endtask

  task automatic drainAll(input logic validRandom, input logic readyRandom,
                          input logic readyLevel, input string what);
    int cycles;
    cycles = 0;
    while (!allDelivered() && cycles < DrainLimit) begin
      driveCycle(validRandom, readyRandom, readyLevel);
      cycles++;
    end
    if (!allDelivered()) begin
      $display("Timeout: %s did not drain within %0d cycles", what, DrainLimit);
      otherCount++;
    end
  endtask

  task automatic checkCounts(input int expected, input string what);
    if (acceptedCount != expected || outCount != expected) begin
      $display("Mismatch at %0t: %s accepted %0d delivered %0d expected %0d",
               $time, what, acceptedCount, outCount, expected);
      mismatchCount++;
    end
  endtask

  // --------------------------------------------------
  // Tests
  // --------------------------------------------------
  task automatic testResetState();
    @(negedge clk);
    if (outValid !== 1'b0) begin
      $display("Mismatch at %0t: outValid %b after reset", $time, outValid);
      mismatchCount++;
    end
    if (inReady !== '1) begin
      $display("Mismatch at %0t: inReady %b after reset", $time, inReady);
      mismatchCount++;
    end
  endtask

  // Flow 1 so the tag is not the reset value of select
  task automatic testSingleFlow();
    acceptedCount = 0;
    outCount      = 0;
    for (int i = 0; i < SingleWords; i++) pendQ[1].push_back(randomWord());
    drainAll(1'b0, 1'b0, 1'b1, "single flow");
    checkCounts(SingleWords, "single flow");
  endtask

  task automatic testRoundRobin();
    int cycles;
    for (int f = 0; f < NumFlows; f++) begin
      for (int i = 0; i < FifoDepth; i++) pendQ[f].push_back(randomWord());
    end
    // Preload with the consumer stalled
    cycles = 0;
    while (!pendingEmpty() && cycles < DrainLimit) begin
      driveCycle(1'b0, 1'b0, 1'b0);
      cycles++;
    end
    if (!pendingEmpty()) begin
      $display("Timeout: queues were not preloaded for round robin");
      otherCount++;
    end
    rrHavePrev = 1'b0;
    rrCheck    = 1'b1;
    drainAll(1'b0, 1'b0, 1'b1, "round robin");
    rrCheck    = 1'b0;
  endtask

  task automatic testBackPressure();
    int cycles;
    acceptedCount = 0;
    outCount      = 0;
    stallSeen     = '0;
    for (int i = 0; i < PressureWords; i++) pendQ[2].push_back(randomWord());
    cycles = 0;
    while (!stallSeen[2] && cycles < DrainLimit) begin
      driveCycle(1'b0, 1'b0, 1'b0);
      cycles++;
    end
    if (!stallSeen[2]) begin
      $display("inReady of flow 2 never fell while outReady was held low");
      otherCount++;
    end
    drainAll(1'b0, 1'b0, 1'b1, "back-pressure");
    checkCounts(PressureWords, "back-pressure");
  endtask

  task automatic testRandomTraffic();
    acceptedCount = 0;
    outCount      = 0;
    for (int f = 0; f < NumFlows; f++) begin
      for (int i = 0; i < RandomWords; i++) pendQ[f].push_back(randomWord());
    end
    drainAll(1'b1, 1'b1, 1'b0, "random traffic");
    checkCounts(NumFlows * RandomWords, "random traffic");
  endtask

  initial begin
    arstN         = 1'b0;
    inValid       = '0;
    inData        = '0;
    outReady      = 1'b0;
    stallSeen     = '0;
    rrCheck       = 1'b0;
    rrHavePrev    = 1'b0;
    rrPrev        = 0;
    mismatchCount = 0;
    otherCount    = 0;
    acceptedCount = 0;
    outCount      = 0;
    repeat (ResetCycles) @(posedge clk);
    arstN <= 1'b1;
    testResetState();
    testSingleFlow();
    testRoundRobin();
    testBackPressure();
    testRandomTraffic();
    $display("Errors: %0d mismatches, %0d other failures", mismatchCount, otherCount);
    if (mismatchCount == 0 && otherCount == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule : tbFlowMux

//--- verilog.f
design/flowCfgPkg.sv
design/flowTypesPkg.sv
design/flowFifo.sv
design/flowSelectScheduler.sv
design/flowMuxSelect.sv
design/flowSkidBuffer.sv
design/flowMuxTop.sv
testbench/tbFlowMux.sv
